//--- common/radio_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, types and constants of the radio command path
// Setting addresses are 8 bits and readback selects are 3 bits wide
////////////////////////////////////////////////////////////////////////////

package radio_pkg;

   // Plain vector types
   typedef logic [63:0] word_t;
   typedef logic [31:0] reg32_t;
   typedef logic [7:0]  set_addr_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [2:0]  rb_sel_t;

   // One stream beat, valid and ready travel beside it
   typedef struct packed {
      logic  tlast;
      word_t tdata;
   } axis_beat_t;

   // Settings bus, stb is a one-cycle pulse
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      reg32_t    data;
   } set_bus_t;

   typedef enum logic [2:0] {
      st_header,
      st_payload,
      st_strobe,
      st_resp_hdr,
      st_resp_data,
      st_drop
   } ctrl_state_t;

   // Packet type in header bits 63:62
   localparam logic [1:0] PKT_DATA = 2'd0;
   localparam logic [1:0] PKT_FC   = 2'd1;
   localparam logic [1:0] PKT_CMD  = 2'd2;
   localparam logic [1:0] PKT_RESP = 2'd3;

   ////////////////////////////////////////////////////////////////////////////
   // Setting addresses
   localparam set_addr_t SR_DACSYNC    = 8'd5;
   localparam set_addr_t SR_TEST       = 8'd7;
   localparam set_addr_t SR_MISC_OUTS  = 8'd24;
   localparam set_addr_t SR_READBACK   = 8'd127;
   localparam set_addr_t SR_TIME_LO    = 8'd128;
   localparam set_addr_t SR_TIME_HI    = 8'd129;
   localparam set_addr_t SR_CODEC_IDLE = 8'd250;

   ////////////////////////////////////////////////////////////////////////////
   // Readback map
   localparam rb_sel_t RB_TEST      = 3'd0;
   localparam rb_sel_t RB_TIME      = 3'd1;
   localparam rb_sel_t RB_TIME_PPS  = 3'd2;
   localparam rb_sel_t RB_IDLE_TEST = 3'd3;
   localparam rb_sel_t RB_MISC      = 3'd4;
   localparam rb_sel_t RB_RADIO_NUM = 3'd6;

   localparam logic [7:0] MISC_RESET = 8'd0;

endpackage

//--- ctrl/radio_ctrl_proc.sv
////////////////////////////////////////////////////////////////////////////
// One settings write per command packet, answered by a two-beat response
// Input stalls while a response is pending, so back-pressure loses nothing
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module radio_ctrl_proc
   import radio_pkg::*;
(
   input  logic       radio_clk,
   input  logic       i_reset,
   input  axis_beat_t i_cmd,
   input  logic       i_cmd_valid,
   output logic       o_cmd_ready,
   output axis_beat_t o_resp,
   output logic       o_resp_valid,
   input  logic       i_resp_ready,
   output set_bus_t   o_set,
   input  word_t      i_readback
);

   ctrl_state_t state;
   word_t       hdr_q;
   word_t       rb_q;
   logic        more_q;
   logic        set_stb;
   set_addr_t   set_addr;
   reg32_t      set_data;
   logic        rb_capture;
   logic        cmd_xfer;
   logic        resp_xfer;

   assign cmd_xfer  = i_cmd_valid && o_cmd_ready;
   assign resp_xfer = o_resp_valid && i_resp_ready;

   // Accept input only while no command is in flight
   assign o_cmd_ready = (state == st_header) || (state == st_payload) ||
                        (state == st_drop);

   ////////////////////////////////////////////////////////////////////////////
   // Packet FSM
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         state      <= st_header;
         set_stb    <= 1'b0;
         rb_capture <= 1'b0;
         more_q     <= 1'b0;
      end else begin
         set_stb    <= 1'b0;
         rb_capture <= set_stb;
         case (state)
            st_header: begin
               if (cmd_xfer) begin
                  if (i_cmd.tdata[63:62] != PKT_CMD || i_cmd.tlast) begin
                     state <= i_cmd.tlast ? st_header : st_drop;
                  end else begin
                     state <= st_payload;
                  end
               end
            end
            st_payload: begin
               if (cmd_xfer) begin
                  set_stb <= 1'b1;
                  more_q  <= !i_cmd.tlast;
                  state   <= st_strobe;
               end
            end
            // Registers take the write at the end of this cycle
            st_strobe:   state <= st_resp_hdr;
            st_resp_hdr: begin
               if (resp_xfer) begin
                  state <= st_resp_data;
               end
            end
            st_resp_data: begin
               if (resp_xfer) begin
                  state <= more_q ? st_drop : st_header;
               end
            end
            st_drop: begin
               if (cmd_xfer && i_cmd.tlast) begin
                  state <= st_header;
               end
            end
            default: state <= st_header;
         endcase
      end
   end

   // Header, setting word and readback capture
   always_ff @(posedge radio_clk) begin
      if (state == st_header && cmd_xfer) begin
         hdr_q <= i_cmd.tdata;
      end
      if (state == st_payload && cmd_xfer) begin
         set_addr <= i_cmd.tdata[39:32];
         set_data <= i_cmd.tdata[31:0];
      end
      // First cycle of the header beat, after the registers took the write
      if (rb_capture) begin
         rb_q <= i_readback;
      end
   end

   assign o_set = '{stb: set_stb, addr: set_addr, data: set_data};

   ////////////////////////////////////////////////////////////////////////////
   // Response stream
   assign o_resp_valid = (state == st_resp_hdr) || (state == st_resp_data);

   always_comb begin
      if (state == st_resp_hdr) begin
         o_resp.tlast = 1'b0;
         o_resp.tdata = {PKT_RESP, hdr_q[61:0]};
      end else begin
         o_resp.tlast = 1'b1;
         o_resp.tdata = rb_q;
      end
   end

   // A stalled beat holds until it transfers
   a_resp_stable: assert property (@(posedge radio_clk) disable iff (i_reset)
      o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp));

endmodule

//--- logic/radio_regs.sv
////////////////////////////////////////////////////////////////////////////
// Setting registers, DAC sync pulse and readback multiplexer
// Writes land on the edge that ends the strobe cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module radio_regs
   import radio_pkg::*;
#(
   parameter int RADIO_NUM = 0
) (
   input  logic       radio_clk,
   input  logic       i_reset,
   input  set_bus_t   i_set,
   input  vita_time_t i_vita_time,
   input  vita_time_t i_vita_time_pps,
   output reg32_t     o_tx,
   output logic [7:0] o_misc_outs,
   output logic       o_sync_dacs,
   output word_t      o_readback
);

   reg32_t     test_q;
   reg32_t     idle_q;
   rb_sel_t    rb_sel_q;
   logic [7:0] misc_q;
   logic       sync_q;

   ////////////////////////////////////////////////////////////////////////////
   // Address decode
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         test_q   <= '0;
         idle_q   <= '0;
         rb_sel_q <= '0;
         misc_q   <= MISC_RESET;
         sync_q   <= 1'b0;
      end else begin
         // Any write to the sync address fires the pulse
         sync_q <= i_set.stb && (i_set.addr == SR_DACSYNC);
         if (i_set.stb) begin
            case (i_set.addr)
               SR_TEST:       test_q   <= i_set.data;
               SR_READBACK:   rb_sel_q <= i_set.data[2:0];
               SR_MISC_OUTS:  misc_q   <= i_set.data[7:0];
               SR_CODEC_IDLE: idle_q   <= i_set.data;
               default:       ;
            endcase
         end
      end
   end

   // No DSP, so the codec sees the idle word
   assign o_tx        = idle_q;
   assign o_misc_outs = misc_q;
   assign o_sync_dacs = sync_q;

   ////////////////////////////////////////////////////////////////////////////
   // Readback multiplexer
   always_comb begin
      case (rb_sel_q)
         RB_TEST:      o_readback = {32'd0, test_q};
         RB_TIME:      o_readback = i_vita_time;
         RB_TIME_PPS:  o_readback = i_vita_time_pps;
         RB_IDLE_TEST: o_readback = {idle_q, test_q};
         RB_MISC:      o_readback = {56'd0, misc_q};
         RB_RADIO_NUM: o_readback = word_t'(RADIO_NUM);
         default:      o_readback = '0;
      endcase
   end

   // Strobe is a single-cycle pulse from the command parser
   a_sync_single: assert property (@(posedge radio_clk) disable iff (i_reset)
      o_sync_dacs |=> !o_sync_dacs);

endmodule

//--- logic/timekeeper.sv
////////////////////////////////////////////////////////////////////////////
// Vita time counter, one count per radio_clk cycle
// Time load takes two writes, low word first, then high word
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module timekeeper
   import radio_pkg::*;
(
   input  logic       radio_clk,
   input  logic       i_reset,
   input  set_bus_t   i_set,
   input  logic       i_pps,
   output vita_time_t o_vita_time,
   output vita_time_t o_vita_time_pps
);

   vita_time_t time_q;
   vita_time_t time_pps_q;
   reg32_t     lo_pending;
   logic       pps_q;
   logic       pps_d;

   // Low word waits here until the high word arrives
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         lo_pending <= '0;
      end else if (i_set.stb && i_set.addr == SR_TIME_LO) begin
         lo_pending <= i_set.data;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         time_q <= '0;
      end else if (i_set.stb && i_set.addr == SR_TIME_HI) begin
         time_q <= {i_set.data, lo_pending};
      end else begin
         time_q <= time_q + 64'd1;
      end
   end

   // pps sampled, then edge detected
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         pps_q      <= 1'b0;
         pps_d      <= 1'b0;
         time_pps_q <= '0;
      end else begin
         pps_q <= i_pps;
         pps_d <= pps_q;
         if (pps_q && !pps_d) begin
            time_pps_q <= time_q;
         end
      end
   end

   assign o_vita_time     = time_q;
   assign o_vita_time_pps = time_pps_q;

endmodule

//--- logic/radio_core.sv
////////////////////////////////////////////////////////////////////////////
// Radio command path top, single radio_clk domain
// Only type 2 packets are acted on, everything else is dropped
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module radio_core
   import radio_pkg::*;
#(
   parameter int RADIO_NUM = 0
) (
   input  logic       radio_clk,
   input  logic       i_reset,
   input  axis_beat_t i_cmd,
   input  logic       i_cmd_valid,
   output logic       o_cmd_ready,
   output axis_beat_t o_resp,
   output logic       o_resp_valid,
   input  logic       i_resp_ready,
   input  logic       i_pps,
   output reg32_t     o_tx,
   output logic [7:0] o_misc_outs,
   output logic       o_sync_dacs
);

   set_bus_t   set_bus;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   word_t      readback;

   radio_ctrl_proc radio_ctrl_proc0 (
      .radio_clk    (radio_clk),
      .i_reset      (i_reset),
      .i_cmd        (i_cmd),
      .i_cmd_valid  (i_cmd_valid),
      .o_cmd_ready  (o_cmd_ready),
      .o_resp       (o_resp),
      .o_resp_valid (o_resp_valid),
      .i_resp_ready (i_resp_ready),
      .o_set        (set_bus),
      .i_readback   (readback)
   );

   radio_regs #(.RADIO_NUM(RADIO_NUM)) radio_regs0 (
      .radio_clk       (radio_clk),
      .i_reset         (i_reset),
      .i_set           (set_bus),
      .i_vita_time     (vita_time),
      .i_vita_time_pps (vita_time_pps),
      .o_tx            (o_tx),
      .o_misc_outs     (o_misc_outs),
      .o_sync_dacs     (o_sync_dacs),
      .o_readback      (readback)
   );

   timekeeper timekeeper0 (
      .radio_clk       (radio_clk),
      .i_reset         (i_reset),
      .i_set           (set_bus),
      .i_pps           (i_pps),
      .o_vita_time     (vita_time),
      .o_vita_time_pps (vita_time_pps)
   );

endmodule

//--- dv/tb_clock.sv
////////////////////////////////////////////////////////////////////////////
// Free-running radio_clk, 100 ns period, starts low
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock (
   output logic o_clk
);

   localparam int HALF_PERIOD = 50;

   initial begin
      o_clk = 1'b0;
      forever begin
         #HALF_PERIOD o_clk = ~o_clk;
      end
   end

endmodule

//--- dv/tb_checker.sv
////////////////////////////////////////////////////////////////////////////
// Response stream monitor, samples on the falling edge where all is stable
// Expectations arrive in order, one per command that must be answered
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_checker
   import radio_pkg::*;
(
   input  logic       radio_clk,
   input  logic       i_reset,
   input  axis_beat_t i_resp,
   input  logic       i_resp_valid,
   input  logic       i_resp_ready,
   input  logic       i_sync_dacs,
   input  reg32_t     i_tx,
   input  logic [7:0] i_misc_outs,
   input  logic       i_exp_push,
   input  word_t      i_exp_hdr,
   input  word_t      i_exp_data,
   input  logic       i_exp_exact,
   input  logic       i_exp_pps,
   input  logic       i_exp_after_pps,
   input  logic       i_exp_sync,
   input  reg32_t     i_exp_tx,
   input  logic [7:0] i_exp_misc,
   input  logic       i_done,
   output int         o_errors,
   output int         o_checks,
   output int         o_pending
);

   typedef struct packed {
      word_t      hdr;
      word_t      data;
      logic       exact;
      logic       pps;
      logic       after_pps;
      logic       sync;
      reg32_t     tx;
      logic [7:0] misc;
   } resp_exp_t;

   resp_exp_t exp_q[$];
   resp_exp_t item;
   resp_exp_t cur;
   int        errors    = 0;
   int        checks    = 0;
   int        pending   = 0;
   int        sync_cnt  = 0;
   logic      in_data   = 1'b0;
   logic      done_seen = 1'b0;
   word_t     pps_time  = '0;

   task automatic compare_word(input string name, input word_t exp_val, input word_t act_val);
      checks++;
      if (act_val !== exp_val) begin
         errors++;
         $display("** Error at time %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
      end
   endtask

   always @(negedge radio_clk) begin
      if (i_reset) begin
         sync_cnt = 0;
         in_data  = 1'b0;
      end else begin
         if (i_exp_push) begin
            item = {i_exp_hdr, i_exp_data, i_exp_exact, i_exp_pps, i_exp_after_pps,
                    i_exp_sync, i_exp_tx, i_exp_misc};
            exp_q.push_back(item);
         end
         if (i_sync_dacs) begin
            sync_cnt++;
         end
         if (i_resp_valid && i_resp_ready) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("Unexpected response beat at time %0t with no command pending", $time);
            end else if (!in_data) begin
               // Header beat, the entry stays queued until its data beat
               compare_word("o_resp.tdata", exp_q[0].hdr, i_resp.tdata);
               compare_word("o_resp.tlast", 64'd0, {63'd0, i_resp.tlast});
               in_data = 1'b1;
            end else begin
               cur = exp_q.pop_front();
               compare_word("o_resp.tlast", 64'd1, {63'd0, i_resp.tlast});
               if (cur.exact) begin
                  compare_word("o_resp.tdata", cur.data, i_resp.tdata);
               end
               if (cur.pps) begin
                  checks++;
                  pps_time = i_resp.tdata;
                  if (i_resp.tdata == '0) begin
                     errors++;
                     $display("The pps time read back as zero at time %0t", $time);
                  end
               end
               if (cur.after_pps && i_resp.tdata < pps_time) begin
                  errors++;
                  $display("Time %h read at %0t is earlier than pps time %h",
                           i_resp.tdata, $time, pps_time);
               end
               compare_word("o_sync_dacs pulses", {63'd0, cur.sync}, 64'(sync_cnt));
               compare_word("o_tx", {32'd0, cur.tx}, {32'd0, i_tx});
               compare_word("o_misc_outs", {56'd0, cur.misc}, {56'd0, i_misc_outs});
               in_data  = 1'b0;
               sync_cnt = 0;
            end
         end
         if (i_done && !done_seen) begin
            done_seen = 1'b1;
            if (exp_q.size() != 0) begin
               errors += exp_q.size();
               $display("%0d expected responses never arrived", exp_q.size());
            end
         end
      end
      pending = exp_q.size();
   end

   assign o_errors  = errors;
   assign o_checks  = checks;
   assign o_pending = pending;

endmodule

//--- dv/tb_radio.sv
////////////////////////////////////////////////////////////////////////////
// Command path testbench, one table row per packet, random back-pressure
// Expected readback comes from a small model of the register map
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_radio
   import radio_pkg::*;
();

   localparam int NUM_ROWS     = 20;
   localparam int RESET_CYCLES = 10;
   localparam int ROW_CYCLES   = 40;
   localparam int READY_WAIT   = 40;
   localparam int DRIVE_DELAY  = 10;

   // Response kinds
   localparam logic [2:0] K_NONE      = 3'd0;
   localparam logic [2:0] K_EXACT     = 3'd1;
   localparam logic [2:0] K_ANY       = 3'd2;
   localparam logic [2:0] K_PPS       = 3'd3;
   localparam logic [2:0] K_AFTER_PPS = 3'd4;

   typedef struct packed {
      logic [1:0] ptype;
      logic       hdr_last;
      set_addr_t  addr;
      reg32_t     data;
      logic       rand_data;
      logic [2:0] extra;
      logic       pps_before;
      logic [2:0] kind;
   } row_t;

   logic       radio_clk;
   logic       i_reset;
   axis_beat_t i_cmd;
   logic       i_cmd_valid;
   logic       o_cmd_ready;
   axis_beat_t o_resp;
   logic       o_resp_valid;
   logic       i_resp_ready;
   logic       i_pps;
   reg32_t     o_tx;
   logic [7:0] o_misc_outs;
   logic       o_sync_dacs;
   logic       exp_push;
   word_t      exp_hdr;
   word_t      exp_data;
   logic       exp_exact;
   logic       exp_pps;
   logic       exp_after;
   logic       exp_sync;
   reg32_t     exp_tx;
   logic [7:0] exp_misc;
   logic       done;
   int         chk_errors;
   int         chk_checks;
   int         chk_pending;
   int         tb_errors = 0;
   row_t       rows [NUM_ROWS];
   logic [31:0] rng_state = 32'h8727;

   // Register model
   reg32_t     m_test;
   reg32_t     m_idle;
   reg32_t     m_lo;
   logic [7:0] m_misc;
   rb_sel_t    m_sel;
   word_t      m_time;

   tb_clock clock0 (.o_clk(radio_clk));

   radio_core #(.RADIO_NUM(3)) dut0 (
      .radio_clk    (radio_clk),
      .i_reset      (i_reset),
      .i_cmd        (i_cmd),
      .i_cmd_valid  (i_cmd_valid),
      .o_cmd_ready  (o_cmd_ready),
      .o_resp       (o_resp),
      .o_resp_valid (o_resp_valid),
      .i_resp_ready (i_resp_ready),
      .i_pps        (i_pps),
      .o_tx         (o_tx),
      .o_misc_outs  (o_misc_outs),
      .o_sync_dacs  (o_sync_dacs)
   );

   tb_checker checker0 (
      .radio_clk (radio_clk), .i_reset (i_reset), .i_resp (o_resp),
      .i_resp_valid (o_resp_valid), .i_resp_ready (i_resp_ready),
      .i_sync_dacs (o_sync_dacs), .i_tx (o_tx), .i_misc_outs (o_misc_outs),
      .i_exp_push (exp_push), .i_exp_hdr (exp_hdr), .i_exp_data (exp_data),
      .i_exp_exact (exp_exact), .i_exp_pps (exp_pps), .i_exp_after_pps (exp_after),
      .i_exp_sync (exp_sync), .i_exp_tx (exp_tx), .i_exp_misc (exp_misc),
      .i_done (done), .o_errors (chk_errors), .o_checks (chk_checks),
      .o_pending (chk_pending)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic draw_random(output logic [31:0] r);
      rng_state = xorshift32(rng_state);
      r = rng_state;
   endtask

   task automatic next_cycle();
      @(posedge radio_clk);
      #DRIVE_DELAY;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Register model, follows the readback map
   task automatic model_write(input set_addr_t addr, input reg32_t data);
      case (addr)
         SR_TEST:       m_test = data;
         SR_READBACK:   m_sel  = data[2:0];
         SR_MISC_OUTS:  m_misc = data[7:0];
         SR_CODEC_IDLE: m_idle = data;
         SR_TIME_LO:    m_lo   = data;
         SR_TIME_HI:    m_time = {data, m_lo};
         default:       ;
      endcase
   endtask

   function automatic word_t model_readback();
      case (m_sel)
         RB_TEST:      return {32'd0, m_test};
         RB_TIME:      return m_time;
         RB_IDLE_TEST: return {m_idle, m_test};
         RB_MISC:      return {56'd0, m_misc};
         RB_RADIO_NUM: return 64'd3;
         default:      return 64'd0;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Drivers
   task automatic send_beat(input word_t data, input logic last);
      int   waited;
      logic xfer;
      waited = 0;
      xfer = 1'b0;
      i_cmd.tlast = last;
      i_cmd.tdata = data;
      i_cmd_valid = 1'b1;
      // Ready only changes on an edge, so its value now decides the next edge
      while (!xfer && waited < READY_WAIT) begin
         xfer = o_cmd_ready;
         next_cycle();
         waited++;
      end
      i_cmd_valid = 1'b0;
      if (!xfer) begin
         tb_errors++;
         $display("Command input stalled, beat %h never accepted by time %0t", data, $time);
      end
   endtask

   task automatic pulse_pps();
      i_pps = 1'b1;
      repeat (3) next_cycle();
      i_pps = 1'b0;
      repeat (4) next_cycle();
   endtask

   task automatic push_expect(input word_t hdr, input row_t r);
      exp_hdr   = {PKT_RESP, hdr[61:0]};
      exp_data  = model_readback();
      exp_exact = (r.kind == K_EXACT);
      exp_pps   = (r.kind == K_PPS);
      exp_after = (r.kind == K_AFTER_PPS);
      exp_sync  = (r.addr == SR_DACSYNC);
      exp_tx    = m_idle;
      exp_misc  = m_misc;
      exp_push  = 1'b1;
      next_cycle();
      exp_push  = 1'b0;
   endtask

   task automatic apply_row(input row_t r, input int idx);
      word_t  hdr;
      reg32_t data;
      int     n_beats;
      if (r.pps_before) begin
         pulse_pps();
      end
      data = r.data;
      if (r.rand_data) begin
         draw_random(data);
      end
      hdr = {r.ptype, 30'd0, idx[15:0], 16'hC0DE};
      if (r.ptype == PKT_CMD && !r.hdr_last) begin
         model_write(r.addr, data);
      end
      if (r.kind != K_NONE) begin
         push_expect(hdr, r);
      end
      n_beats = r.hdr_last ? 0 : int'(r.extra) + ((r.ptype == PKT_CMD) ? 1 : 0);
      send_beat(hdr, n_beats == 0);
      for (int k = 1; k <= n_beats; k++) begin
         if (k == 1 && r.ptype == PKT_CMD) begin
            send_beat({24'd0, r.addr, data}, k == n_beats);
         end else begin
            send_beat({16'hBEEF, idx[15:0], k[31:0]}, k == n_beats);
         end
      end
   endtask

   // Back-pressure, drawn on the edge and driven after the drive delay
   initial begin
      logic [31:0] r;
      i_resp_ready = 1'b0;
      forever begin
         @(posedge radio_clk);
         draw_random(r);
         #DRIVE_DELAY;
         i_resp_ready = (r[1:0] != 2'b00);
      end
   end

   initial begin
      repeat (NUM_ROWS * ROW_CYCLES + RESET_CYCLES) @(posedge radio_clk);
      $display("Watchdog timeout, run not finished after %0d cycles",
               NUM_ROWS * ROW_CYCLES + RESET_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      int waited;
      i_reset     = 1'b1;
      i_cmd       = '0;
      i_cmd_valid = 1'b0;
      i_pps       = 1'b0;
      exp_push    = 1'b0;
      exp_hdr     = '0;
      exp_data    = '0;
      exp_exact   = 1'b0;
      exp_pps     = 1'b0;
      exp_after   = 1'b0;
      exp_sync    = 1'b0;
      exp_tx      = '0;
      exp_misc    = '0;
      done        = 1'b0;
      m_test      = '0;
      m_idle      = '0;
      m_lo        = '0;
      m_misc      = MISC_RESET;
      m_sel       = RB_TEST;
      m_time      = '0;

      // type, header last, address, data, random data, extra beats, pps first, response
      rows[0]  = '{PKT_CMD,  1'b0, SR_READBACK,   32'(RB_TEST),      1'b0, 3'd0, 1'b0, K_EXACT};
      rows[1]  = '{PKT_CMD,  1'b0, SR_TEST,       32'd0,             1'b1, 3'd0, 1'b0, K_EXACT};
      rows[2]  = '{PKT_DATA, 1'b0, SR_TEST,       32'd0,             1'b0, 3'd2, 1'b0, K_NONE};
      rows[3]  = '{PKT_FC,   1'b0, SR_TEST,       32'd0,             1'b0, 3'd1, 1'b0, K_NONE};
      rows[4]  = '{PKT_CMD,  1'b1, 8'd0,          32'd0,             1'b0, 3'd0, 1'b0, K_NONE};
      rows[5]  = '{PKT_CMD,  1'b0, SR_TEST,       32'd0,             1'b1, 3'd2, 1'b0, K_EXACT};
      rows[6]  = '{PKT_CMD,  1'b0, SR_CODEC_IDLE, 32'hA5A5_0F0F,     1'b0, 3'd0, 1'b0, K_EXACT};
      rows[7]  = '{PKT_CMD,  1'b0, SR_READBACK,   32'(RB_IDLE_TEST), 1'b0, 3'd0, 1'b0, K_EXACT};
      rows[8]  = '{PKT_CMD,  1'b0, SR_MISC_OUTS,  32'h0000_005C,     1'b0, 3'd0, 1'b0, K_EXACT};
      rows[9]  = '{PKT_CMD,  1'b0, SR_READBACK,   32'(RB_MISC),      1'b0, 3'd0, 1'b0, K_EXACT};
      rows[10] = '{PKT_CMD,  1'b0, SR_DACSYNC,    32'd0,             1'b0, 3'd0, 1'b0, K_EXACT};
      rows[11] = '{PKT_CMD,  1'b0, SR_READBACK,   32'(RB_RADIO_NUM), 1'b0, 3'd0, 1'b0, K_EXACT};
      rows[12] = '{PKT_CMD,  1'b0, SR_READBACK,   32'd5,             1'b0, 3'd0, 1'b0, K_EXACT};
      rows[13] = '{PKT_CMD,  1'b0, SR_READBACK,   32'(RB_TIME),      1'b0, 3'd0, 1'b0, K_ANY};
      rows[14] = '{PKT_CMD,  1'b0, SR_TIME_LO,    32'h89AB_CDEF,     1'b0, 3'd0, 1'b0, K_ANY};
      rows[15] = '{PKT_CMD,  1'b0, SR_TIME_HI,    32'h0000_0123,     1'b0, 3'd0, 1'b0, K_EXACT};
      rows[16] = '{PKT_CMD,  1'b0, SR_READBACK,   32'(RB_TIME_PPS),  1'b0, 3'd0, 1'b1, K_PPS};
      rows[17] = '{PKT_CMD,  1'b0, SR_READBACK,   32'(RB_TIME),      1'b0, 3'd0, 1'b0, K_AFTER_PPS};
      rows[18] = '{PKT_CMD,  1'b0, SR_READBACK,   32'(RB_TEST),      1'b0, 3'd0, 1'b0, K_EXACT};
      rows[19] = '{PKT_CMD,  1'b0, SR_TEST,       32'd0,             1'b1, 3'd0, 1'b0, K_EXACT};

      repeat (RESET_CYCLES) @(posedge radio_clk);
      #DRIVE_DELAY;
      i_reset = 1'b0;

      for (int i = 0; i < NUM_ROWS; i++) begin
         apply_row(rows[i], i);
      end

      // Let the last responses drain
      waited = 0;
      while (chk_pending != 0 && waited < ROW_CYCLES) begin
         next_cycle();
         waited++;
      end
      done = 1'b1;
      next_cycle();

      $display("Checks: %0d, errors: %0d", chk_checks, chk_errors + tb_errors);
      if (chk_errors + tb_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- project.f
common/radio_pkg.sv
ctrl/radio_ctrl_proc.sv
logic/radio_regs.sv
logic/timekeeper.sv
logic/radio_core.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_radio.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert
TOP       := tb_radio
FILELIST  := project.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
